// ==== design/px_bus_ctl.sv ====
// System bus request for memory states, response wait, alarm and write protection
`timescale 1ns/1ps

module px_bus_ctl #(
	parameter px_pkg::px_dly_t alarm_ticks = 8'd20
) (
	input logic got,
	input logic clo_,
	input px_pkg::px_state_t state,
	input logic cycle_end,
	input logic q, // System flag, user mode
	input logic arz, // Address in low memory
	input logic rok, // Memory done
	input logic ren, // No memory
	input px_pkg::px_cfg_t cfg,
	output logic zg,
	output logic dr,
	output logic dw,
	output logic bus_busy,
	output px_pkg::px_status_t fault_ev
);

	typedef enum logic [1:0] {
		B_IDLE, // Waiting for a bus state
		B_REQ, // zg raised, waiting for answer
		B_DONE // Access over for this cycle
	} bus_t;

	bus_t bst;
	px_pkg::px_dly_t wait_cnt; // Cycles of zg so far
	logic rd_st;
	logic wr_st;
	logic deny;

	assign rd_st = state.k1 | state.p1 | state.p5 | state.wr;
	assign wr_st = state.ww | state.wm;

	// User mode write to protected low memory
	assign deny = wr_st & cfg.low_mem_deny & q & arz;

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			bst <= B_IDLE;
			wait_cnt <= '0;
			fault_ev <= '0;
		end else begin
			fault_ev <= '0; // Events are single pulses
			if (cycle_end) begin
				bst <= B_IDLE; // Rearm for the next state
			end else begin
				case (bst)
					B_IDLE: begin
						if (deny) begin
							bst <= B_DONE; // No bus cycle at all
							fault_ev.wr_deny <= 1'b1;
						end else if (rd_st || wr_st) begin
							bst <= B_REQ;
							wait_cnt <= '0;
						end
					end
					B_REQ: begin
						if (rok) begin
							bst <= B_DONE;
						end else if (ren) begin
							bst <= B_DONE;
							fault_ev.nomem <= 1'b1;
						end else if (wait_cnt == alarm_ticks - 8'd1) begin
							bst <= B_DONE; // Nobody answered
							fault_ev.alarm <= 1'b1;
						end else begin
							wait_cnt <= wait_cnt + 8'd1;
						end
					end
					default: begin
						bst <= B_DONE; // Hold until cycle end
					end
				endcase
			end
		end
	end

	assign zg = (bst == B_REQ);
	assign bus_busy = zg; // Stretches the cycle
	assign dr = zg & rd_st;
	assign dw = zg & wr_st;

endmodule

// ==== design/px_ctl_regs.sv ====
// Configuration register, sticky fault status and halt level for the P-X block
`timescale 1ns/1ps

module px_ctl_regs (
	input logic got,
	input logic clo_,
	input logic cfg_we,
	input px_pkg::px_cfg_t cfg_wdata,
	input px_pkg::px_status_t fault_ev,
	input px_pkg::px_status_t stat_clr, // Write one to clear
	output px_pkg::px_cfg_t cfg,
	output px_pkg::px_status_t status,
	output logic hlt
);

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			cfg <= px_pkg::cfg_rst;
		end else if (cfg_we) begin
			cfg <= cfg_wdata;
		end
	end

	// Set wins over clear in the same cycle
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			status <= '0;
		end else begin
			status <= (status & ~stat_clr) | fault_ev;
		end
	end

	// Stop on missing memory until software clears it
	assign hlt = status.nomem & cfg.stop_on_nomem;

endmodule

// ==== design/px_pkg.sv ====
// Shared types for the P-X state control block, referenced by scoped names
package px_pkg;

	// Delay and timeout counts, in got cycles
	typedef logic [7:0] px_dly_t;

	// One-hot processor state, also used for the enter request
	//   Long states       wz ws we p4 (longer strob1 delay)
	//   Two-strobe states ws we p4 k2 (strob2 follows strob1)
	//   Read states       k1 p1 p5 wr
	//   Write states      ww wm
	//   Bus states        read states plus write states
	typedef struct packed {
		logic k1; // Instruction fetch
		logic k2; // Second fetch word
		logic p0; // Front panel service
		logic p1; // Fetch second word
		logic p2; // Modification
		logic p3; // Pre-modification
		logic p4; // Argument fetch prep
		logic p5; // Argument read
		logic wp;
		logic wa;
		logic wz;
		logic ws;
		logic we;
		logic wr; // Memory read
		logic ww; // Memory write
		logic wm; // Memory modify write
		logic wx;
		logic i1; // Interrupt phases
		logic i2;
	} px_state_t;

	// Configuration register
	typedef struct packed {
		logic stop_on_nomem; // Halt on missing memory
		logic low_mem_deny; // Block writes to low memory in user mode
	} px_cfg_t;

	// Sticky faults, also the layout of event pulses and clear bits
	typedef struct packed {
		logic alarm; // Bus wait timed out
		logic nomem; // Memory answered ren
		logic wr_deny; // Protected write suppressed
	} px_status_t;

	// Configuration after reset
	localparam px_cfg_t cfg_rst = '{stop_on_nomem: 1'b1, low_mem_deny: 1'b0};

endpackage

// ==== design/px_state_reg.sv ====
// One-hot processor state register, loaded with the enter request at cycle end
`timescale 1ns/1ps

module px_state_reg (
	input logic got,
	input logic clo_,
	input px_pkg::px_state_t enter,
	input logic cycle_end,
	output px_pkg::px_state_t state
);

	// Sheet 1 and 2 state flip-flops folded into one register
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			state <= '0; // No state active, treated as short non-bus
		end else if (cycle_end) begin
			state <= enter; // New state visible next cycle
		end
	end

endmodule

// ==== design/px_strobe_gen.sv ====
// Machine cycle timing: delay counter, strob1 and strob2 pulses and cycle end
`timescale 1ns/1ps

module px_strobe_gen #(
	parameter px_pkg::px_dly_t dly_short = 8'd3,
	parameter px_pkg::px_dly_t dly_long = 8'd5
) (
	input logic got,
	input logic clo_,
	input px_pkg::px_state_t state,
	input logic bus_busy,
	input logic hlt,
	input logic mode,
	input logic step,
	output logic strob1,
	output logic strob2,
	output logic cycle_end
);

	typedef enum logic [2:0] {
		S_CNT, // Counting the state delay
		S_STB1, // First strobe
		S_STB2, // Second strobe
		S_END, // Cycle end slot
		S_WAIT // Held by step mode or halt
	} seq_t;

	seq_t st;
	seq_t st_nx;
	px_pkg::px_dly_t cnt; // Cycles since last cycle end
	px_pkg::px_dly_t dly_sel;
	logic long_st;
	logic two_st;
	logic due;
	logic go;

	assign long_st = state.wz | state.ws | state.we | state.p4;
	assign two_st = state.ws | state.we | state.p4 | state.k2;
	assign dly_sel = long_st ? dly_long : dly_short; // Univibrator length by group

	// Strobe next cycle once delay is reached and bus is free
	assign due = (cnt >= dly_sel - 8'd1) && !bus_busy;

	// Step mode needs the step key, halt freezes the cycle
	assign go = !hlt && (!mode || step);

	always_comb begin
		st_nx = st;
		case (st)
			S_CNT: begin
				if (due) st_nx = S_STB1;
			end
			S_STB1: begin
				st_nx = two_st ? S_STB2 : S_END;
			end
			S_STB2: begin
				st_nx = S_END;
			end
			S_END, S_WAIT: begin
				st_nx = go ? S_CNT : S_WAIT; // Restart after cycle end
			end
			default: begin
				st_nx = S_CNT;
			end
		endcase
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			st <= S_CNT;
			cnt <= 8'd1; // As if a cycle end just happened
		end else begin
			st <= st_nx;
			if (cycle_end) begin
				cnt <= 8'd1;
			end else if (st == S_CNT && cnt != 8'hff) begin
				cnt <= cnt + 8'd1; // Saturate on a long bus wait
			end
		end
	end

	assign strob1 = (st == S_STB1);
	assign strob2 = (st == S_STB2);
	assign cycle_end = (st == S_END || st == S_WAIT) && go;

endmodule

// ==== design/px_top.sv ====
// Top level of the P-X state control, wiring state, timing, bus and register blocks
`timescale 1ns/1ps

module px_top #(
	parameter px_pkg::px_dly_t dly_short = 8'd3,
	parameter px_pkg::px_dly_t dly_long = 8'd5,
	parameter px_pkg::px_dly_t alarm_ticks = 8'd20
) (
	input logic got,
	input logic clo_,
	input px_pkg::px_state_t enter,
	input logic mode,
	input logic step,
	input logic q,
	input logic arz,
	input logic rok,
	input logic ren,
	input logic cfg_we,
	input px_pkg::px_cfg_t cfg_wdata,
	input px_pkg::px_status_t stat_clr,
	output px_pkg::px_state_t state,
	output logic strob1,
	output logic strob2,
	output logic cycle_end,
	output logic zg,
	output logic dr,
	output logic dw,
	output logic hlt,
	output px_pkg::px_cfg_t cfg,
	output px_pkg::px_status_t status
);

	logic bus_busy;
	px_pkg::px_status_t fault_ev;

	px_state_reg px_state_reg_i (
		.got(got), .clo_(clo_), .enter(enter), .cycle_end(cycle_end), .state(state)
	);

	px_strobe_gen #(.dly_short(dly_short), .dly_long(dly_long)) px_strobe_gen_i (
		.got(got), .clo_(clo_), .state(state), .bus_busy(bus_busy), .hlt(hlt),
		.mode(mode), .step(step), .strob1(strob1), .strob2(strob2),
		.cycle_end(cycle_end)
	);

	px_bus_ctl #(.alarm_ticks(alarm_ticks)) px_bus_ctl_i (
		.got(got), .clo_(clo_), .state(state), .cycle_end(cycle_end), .q(q),
		.arz(arz), .rok(rok), .ren(ren), .cfg(cfg), .zg(zg), .dr(dr), .dw(dw),
		.bus_busy(bus_busy), .fault_ev(fault_ev)
	);

	px_ctl_regs px_ctl_regs_i (
		.got(got), .clo_(clo_), .cfg_we(cfg_we), .cfg_wdata(cfg_wdata),
		.fault_ev(fault_ev), .stat_clr(stat_clr), .cfg(cfg), .status(status),
		.hlt(hlt)
	);

endmodule

// ==== flist.f ====
design/px_pkg.sv
design/px_state_reg.sv
design/px_strobe_gen.sv
design/px_bus_ctl.sv
design/px_ctl_regs.sv
design/px_top.sv
sim/px_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator; the log decides pass or fail
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module px_tb -f flist.f -o px_sim

./obj_dir/px_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation passed" sim.log; then
	echo "Result: PASS"
else
	echo "Result: FAIL"
	exit 1
fi

// ==== sim/px_tb.sv ====
// Testbench top that drives px_top through a table of machine cycles and checks strobes, bus and faults
`timescale 1ns/1ps

module px_tb;

	localparam int DLY_S = 3; // Short state delay
	localparam int DLY_L = 5; // Long state delay
	localparam int ALARM = 20; // Bus wait limit
	localparam int SAMPLE_DLY = 4; // Just before the rising edge

	localparam logic [1:0] R_NONE = 2'd0; // No bus answer needed
	localparam logic [1:0] R_ROK = 2'd1;
	localparam logic [1:0] R_REN = 2'd2;
	localparam logic [1:0] R_SILENT = 2'd3; // Memory never answers
	localparam logic [1:0] H_NONE = 2'd0;
	localparam logic [1:0] H_STEP = 2'd1; // Step mode released by the step key
	localparam logic [1:0] H_HALT = 2'd2; // Halt on nomem released by stat_clr

	typedef struct packed {
		px_pkg::px_state_t enter;
		logic [1:0] rsp;
		logic q;
		logic arz;
		logic [1:0] hold;
		logic cfg_we;
		px_pkg::px_cfg_t cfg_wdata;
		px_pkg::px_status_t clr;
		logic [7:0] s1; // Minimum strob1 offset from cycle end
		logic two;
		logic zg;
		logic dr;
		logic dw;
		px_pkg::px_status_t stat; // Status at the last strobe slot
	} row_t;

	logic got;
	logic clo_;
	px_pkg::px_state_t enter;
	logic mode;
	logic step;
	logic q;
	logic arz;
	logic rok;
	logic ren;
	logic cfg_we;
	px_pkg::px_cfg_t cfg_wdata;
	px_pkg::px_status_t stat_clr;
	px_pkg::px_state_t state;
	logic strob1;
	logic strob2;
	logic cycle_end;
	logic zg;
	logic dr;
	logic dw;
	logic hlt;
	px_pkg::px_cfg_t cfg;
	px_pkg::px_status_t status;

	row_t rows[$];
	logic [31:0] seed = 32'hbe58;

	px_top px_top_i (
		.got(got), .clo_(clo_), .enter(enter), .mode(mode), .step(step), .q(q), .arz(arz),
		.rok(rok), .ren(ren), .cfg_we(cfg_we), .cfg_wdata(cfg_wdata), .stat_clr(stat_clr),
		.state(state), .strob1(strob1), .strob2(strob2), .cycle_end(cycle_end), .zg(zg),
		.dr(dr), .dw(dw), .hlt(hlt), .cfg(cfg), .status(status)
	);

	initial begin
		got = 1'b0;
		forever #5 got = ~got; // 10 ns period
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	// One-hot state where k1 is bit 18 and i2 bit 0, empty for a negative position
	function automatic px_pkg::px_state_t hot(input int pos);
		return (pos < 0) ? '0 : px_pkg::px_state_t'(19'd1 << pos);
	endfunction

	task automatic check(input string test, input string what, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			$display("ERROR %s %s expected %0h actual %0h", test, what, exp, act);
			$display("Simulation failed");
			$fatal(1, "Mismatch stops the run");
		end
	endtask

	task automatic add_row(input int pos, input logic [1:0] rsp, input logic [1:0] qa,
			input logic [1:0] hold, input logic we, input logic [1:0] wdata,
			input logic [2:0] clr, input int s1, input logic [3:0] flags, input logic [2:0] stat);
		row_t r;
		r.enter = hot(pos);
		r.rsp = rsp;
		{r.q, r.arz} = qa;
		r.hold = hold;
		r.cfg_we = we;
		r.cfg_wdata = wdata; // {stop_on_nomem, low_mem_deny}
		r.clr = clr; // {alarm, nomem, wr_deny}
		r.s1 = 8'(s1);
		{r.two, r.zg, r.dr, r.dw} = flags;
		r.stat = stat;
		rows.push_back(r);
	endtask

	task automatic build_table();
		add_row(-1, R_NONE, 2'b00, H_NONE, 1'b0, 2'b00, 3'b000, DLY_S, 4'b0000, 3'b000); // Boot
		add_row(16, R_NONE, 2'b00, H_NONE, 1'b0, 2'b00, 3'b000, DLY_S, 4'b0000, 3'b000); // p0
		add_row(17, R_NONE, 2'b00, H_NONE, 1'b0, 2'b00, 3'b000, DLY_S, 4'b1000, 3'b000); // k2
		add_row(8, R_NONE, 2'b00, H_NONE, 1'b0, 2'b00, 3'b000, DLY_L, 4'b0000, 3'b000); // wz
		add_row(7, R_NONE, 2'b00, H_NONE, 1'b0, 2'b00, 3'b000, DLY_L, 4'b1000, 3'b000); // ws
		add_row(18, R_ROK, 2'b00, H_NONE, 1'b0, 2'b00, 3'b000, DLY_S, 4'b0110, 3'b000); // k1
		add_row(4, R_ROK, 2'b00, H_NONE, 1'b0, 2'b00, 3'b000, DLY_S, 4'b0101, 3'b000); // ww
		add_row(5, R_SILENT, 2'b00, H_NONE, 1'b0, 2'b00, 3'b000, DLY_S, 4'b0110, 3'b100); // wr
		add_row(14, R_NONE, 2'b00, H_NONE, 1'b0, 2'b00, 3'b100, DLY_S, 4'b0000, 3'b000); // p2
		add_row(11, R_REN, 2'b00, H_HALT, 1'b0, 2'b00, 3'b000, DLY_S, 4'b0110, 3'b010); // p5
		add_row(13, R_NONE, 2'b00, H_NONE, 1'b1, 2'b00, 3'b000, DLY_S, 4'b0000, 3'b000); // p3
		add_row(15, R_REN, 2'b00, H_NONE, 1'b0, 2'b00, 3'b000, DLY_S, 4'b0110, 3'b010); // p1
		add_row(10, R_NONE, 2'b00, H_NONE, 1'b1, 2'b01, 3'b010, DLY_S, 4'b0000, 3'b000); // wp
		add_row(3, R_NONE, 2'b11, H_NONE, 1'b0, 2'b00, 3'b000, DLY_S, 4'b0000, 3'b001); // wm
		add_row(3, R_ROK, 2'b10, H_NONE, 1'b0, 2'b00, 3'b000, DLY_S, 4'b0101, 3'b001); // wm
		add_row(2, R_NONE, 2'b00, H_STEP, 1'b0, 2'b00, 3'b001, DLY_S, 4'b0000, 3'b000); // wx
		add_row(12, R_NONE, 2'b00, H_NONE, 1'b0, 2'b00, 3'b000, DLY_L, 4'b1000, 3'b000); // p4
		add_row(1, R_NONE, 2'b00, H_NONE, 1'b0, 2'b00, 3'b000, DLY_S, 4'b0000, 3'b000); // i1
		add_row(0, R_NONE, 2'b00, H_NONE, 1'b0, 2'b00, 3'b000, DLY_S, 4'b0000, 3'b000); // i2
	endtask

	// One machine cycle from the edge after cycle_end up to its own cycle_end
	task automatic run_row(input int i);
		row_t r;
		px_pkg::px_state_t nxt;
		string name;
		int t;
		int zc;
		int d;
		int z_last;
		int s1;
		int t_end;
		int t_ce;
		logic exp_zg;
		logic exp_hlt;
		logic seen_ce;
		r = rows[i];
		nxt = (i + 1 < rows.size()) ? rows[i + 1].enter : '0;
		d = 0;
		if (r.rsp == R_ROK || r.rsp == R_REN) d = int'((lcg_next() >> 16) % 32'd6);
		z_last = (r.rsp == R_SILENT) ? 1 + ALARM : 2 + d; // Last cycle with zg high
		s1 = int'(r.s1);
		if (r.rsp != R_NONE && z_last + 2 > s1) s1 = z_last + 2; // Two after the answer
		t_end = s1 + (r.two ? 2 : 1);
		t_ce = t_end + ((r.hold == H_STEP) ? 3 : ((r.hold == H_HALT) ? 4 : 0));
		t = 0;
		zc = 0;
		seen_ce = 1'b0;
		while (!seen_ce) begin
			@(negedge got);
			t = t + 1;
			rok = 1'b0;
			ren = 1'b0;
			step = 1'b0;
			cfg_we = 1'b0;
			stat_clr = '0;
			if (t == 1) begin
				if (i == 0) clo_ = 1'b1; // Reset release
				enter = nxt; // Loaded at this cycle's end
				q = r.q;
				arz = r.arz;
				mode = (r.hold == H_STEP);
				cfg_we = r.cfg_we;
				cfg_wdata = r.cfg_wdata;
				stat_clr = r.clr;
			end
			if (zg) begin
				zc = zc + 1; // Memory model answers after d extra zg cycles
				if (zc == d + 1) begin
					rok = (r.rsp == R_ROK);
					ren = (r.rsp == R_REN);
				end
			end
			if (t == t_end + 3) begin
				step = (r.hold == H_STEP);
				if (r.hold == H_HALT) stat_clr = 3'b010;
			end
			#(SAMPLE_DLY);
			name = $sformatf("row %0d cycle %0d", i, t);
			exp_zg = r.zg && (t >= 2) && (t <= z_last);
			exp_hlt = (r.hold == H_HALT) && (t >= s1) && (t < t_ce);
			if (t == 1) check(name, "state", 32'(r.enter), 32'(state));
			if (i == 0 && t == 1) begin
				check(name, "status", 32'(0), 32'(status));
				check(name, "cfg", 32'(2'b10), 32'(cfg)); // stop_on_nomem set
			end
			check(name, "strob1", 32'(t == s1), 32'(strob1));
			check(name, "strob2", 32'(r.two && t == s1 + 1), 32'(strob2));
			check(name, "zg", 32'(exp_zg), 32'(zg));
			check(name, "dr", 32'(exp_zg & r.dr), 32'(dr));
			check(name, "dw", 32'(exp_zg & r.dw), 32'(dw));
			check(name, "hlt", 32'(exp_hlt), 32'(hlt));
			if (t == t_end) check(name, "status", 32'(r.stat), 32'(status));
			check(name, "cycle_end", 32'(t == t_ce), 32'(cycle_end));
			seen_ce = cycle_end;
		end
	endtask

	initial begin
		int limit;
		#1;
		limit = (rows.size() * (ALARM + 20) + 16) * 10; // Cycles times period
		#(limit);
		$display("Timeout: the DUT did not finish the cycle table in time");
		$display("Simulation failed");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		clo_ = 1'b0;
		enter = '0;
		mode = 1'b0;
		step = 1'b0;
		q = 1'b0;
		arz = 1'b0;
		rok = 1'b0;
		ren = 1'b0;
		cfg_we = 1'b0;
		cfg_wdata = '0;
		stat_clr = '0;
		build_table();
		repeat (16) @(negedge got); // Reset cycles
		for (int i = 0; i < rows.size(); i++) begin
			run_row(i);
		end
		$display("Simulation passed");
		$finish;
	end

endmodule
